/* common/mem_pkg.sv */
// memory subsystem package: port sizes, latencies and request/response structs

package mem_pkg;

   // -------------------------------------------------------------------------
   // microcode store
   // -------------------------------------------------------------------------
   localparam int MCR_ADDR_W = 14;
   localparam int MCR_WORD_W = 49;
   localparam int MCR_WORDS  = 16384;

   // -------------------------------------------------------------------------
   // main memory
   // -------------------------------------------------------------------------
   localparam int DRAM_ADDR_W  = 22;
   localparam int DRAM_WORDS   = 65536;
   localparam int DRAM_LATENCY = 8;

   // installed size is a power of two, so the index is a plain slice
   localparam int DRAM_IDX_W = $clog2(DRAM_WORDS);
   localparam int DRAM_CNT_W = $clog2(DRAM_LATENCY + 1);

   // -------------------------------------------------------------------------
   // video memory and shared data width
   // -------------------------------------------------------------------------
   localparam int VRAM_ADDR_W = 15;
   localparam int VRAM_WORDS  = 21504;
   localparam int DATA_W      = 32;

   typedef logic [MCR_WORD_W-1:0] mcr_word_t;
   typedef logic [DATA_W-1:0]     data_word_t;
   typedef logic [DRAM_CNT_W-1:0] dram_cnt_t;

   // counter load value, acknowledge follows after this many edges
   localparam dram_cnt_t DRAM_CNT_LOAD = dram_cnt_t'(DRAM_LATENCY);

   typedef struct packed {
      logic [MCR_ADDR_W-1:0] addr;
      mcr_word_t             wdata;
      logic                  we;
   } mcr_req_t;

   typedef struct packed {
      logic [DRAM_ADDR_W-1:0] addr;
      data_word_t             wdata;
      logic                   rd;
      logic                   wr;
   } dram_req_t;

   // ready pulses for a read, done pulses for a write
   typedef struct packed {
      data_word_t rdata;
      logic       ready;
      logic       done;
   } dram_rsp_t;

   typedef struct packed {
      logic [VRAM_ADDR_W-1:0] addr;
      data_word_t             wdata;
      logic                   rd;
      logic                   wr;
   } vram_req_t;

   typedef struct packed {
      data_word_t rdata;
      logic       ready;
      logic       done;
   } vram_rsp_t;

endpackage

/* design/ram_array.sv */
// generic word array with one synchronous write port and one combinational read port

`timescale 1ns/1ps

module ram_array #(
   parameter type word_t = logic [31:0],
   parameter int  DEPTH  = 1024,
   localparam int ADDR_W = $clog2(DEPTH)
) (
   input  logic              clk,
   input  logic              we,
   input  logic [ADDR_W-1:0] waddr,
   input  word_t             wdata,
   input  logic [ADDR_W-1:0] raddr,
   output word_t             rdata
);

   word_t mem [DEPTH];

   // unwritten words read as zero
   initial
   begin
      for (int i = 0; i < DEPTH; i++)
      begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[waddr] <= wdata;
      end
   end

   // read is asynchronous, callers register where they need to
   assign rdata = mem[raddr];

endmodule

/* mcr/mcr_store.sv */
// microcode store: 49-bit control store with prefetch-timed read and write acknowledge

`timescale 1ns/1ps

module mcr_store (
   input  logic                clk,
   input  logic                reset,
   input  logic                prefetch,
   input  mem_pkg::mcr_req_t   req,
   output mem_pkg::mcr_word_t  rdata,
   output logic                done,
   output logic                busy
);

   mem_pkg::mcr_word_t ram_rdata;
   mem_pkg::mcr_word_t rdata_q;
   logic               wr_q;

   ram_array #(
      .word_t (mem_pkg::mcr_word_t),
      .DEPTH  (mem_pkg::MCR_WORDS)
   ) i_ram (
      .clk   (clk),
      .we    (req.we),
      .waddr (req.addr),
      .wdata (req.wdata),
      .raddr (req.addr),
      .rdata (ram_rdata)
   );

   // ---------------------------------------------------------------------------
   // write tracker, high the cycle after each strobed edge
   // ---------------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
         wr_q <= 1'b0;
      else
         wr_q <= req.we;
   end

   // prefetch latch, word stays put until the next prefetch
   always_ff @(posedge clk)
   begin
      if (reset)
         rdata_q <= '0;
      else if (prefetch)
         rdata_q <= ram_rdata;
   end

   assign rdata = rdata_q;

   // same bit tells the video port that a microcode write is under way
   assign done = wr_q;
   assign busy = wr_q;

endmodule

/* dram/dram_port.sv */
// main memory port: single request in flight, fixed latency acknowledge, bounds check

`timescale 1ns/1ps

module dram_port (
   input  logic               clk,
   input  logic               reset,
   input  mem_pkg::dram_req_t req,
   output mem_pkg::dram_rsp_t rsp
);

   mem_pkg::dram_cnt_t  cnt;
   logic                was_rd;
   logic                ready_q;
   logic                done_q;
   mem_pkg::data_word_t rdata_q;
   mem_pkg::data_word_t ram_rdata;

   logic                      idle;
   logic                      accept;
   logic                      in_range;
   logic                      ram_we;
   logic [mem_pkg::DRAM_IDX_W-1:0] idx;

   // ---------------------------------------------------------------------------
   // acceptance and bounds
   // ---------------------------------------------------------------------------
   assign idle   = (cnt == '0);
   assign accept = idle && (req.rd || req.wr);

   // anything with upper address bits set lies past the installed words
   assign in_range = (req.addr[mem_pkg::DRAM_ADDR_W-1:mem_pkg::DRAM_IDX_W] == '0);
   assign idx      = req.addr[mem_pkg::DRAM_IDX_W-1:0];

   // write is done at acceptance, out-of-range writes are dropped
   assign ram_we = accept && req.wr && in_range;

   ram_array #(
      .word_t (mem_pkg::data_word_t),
      .DEPTH  (mem_pkg::DRAM_WORDS)
   ) i_ram (
      .clk   (clk),
      .we    (ram_we),
      .waddr (idx),
      .wdata (req.wdata),
      .raddr (idx),
      .rdata (ram_rdata)
   );

   // ---------------------------------------------------------------------------
   // latency counter and acknowledge
   // ---------------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cnt     <= '0;
         was_rd  <= 1'b0;
         ready_q <= 1'b0;
         done_q  <= 1'b0;
      end
      else
      begin
         // pulse on the edge where the counter runs out
         ready_q <= (cnt == mem_pkg::dram_cnt_t'(1)) && was_rd;
         done_q  <= (cnt == mem_pkg::dram_cnt_t'(1)) && !was_rd;

         if (accept)
         begin
            cnt    <= mem_pkg::DRAM_CNT_LOAD;
            // write wins when both are set
            was_rd <= !req.wr;
         end
         else if (!idle)
            cnt <= cnt - mem_pkg::dram_cnt_t'(1);
      end
   end

   // read data sampled at acceptance
   always_ff @(posedge clk)
   begin
      if (accept && !req.wr)
         rdata_q <= in_range ? ram_rdata : '1;
   end

   assign rsp.rdata = rdata_q;
   assign rsp.ready = ready_q;
   assign rsp.done  = done_q;

endmodule

/* vram/vram_port.sv */
// video memory port: combinational reads, posted writes committed on idle cycles

`timescale 1ns/1ps

module vram_port (
   input  logic               clk,
   input  logic               reset,
   input  logic               fetch,
   input  logic               mcr_busy,
   input  mem_pkg::vram_req_t req,
   output mem_pkg::vram_rsp_t rsp
);

   logic [mem_pkg::VRAM_ADDR_W-1:0] pend_addr;
   mem_pkg::data_word_t             pend_data;
   logic                            pend_valid;

   logic capture;
   logic commit;
   logic ready_q;
   logic done_q;

   // ---------------------------------------------------------------------------
   // holding register control
   // ---------------------------------------------------------------------------

   // only one posted write at a time
   assign capture = req.wr && !pend_valid;

   // memory is free when the sequencer neither fetches nor writes microcode
   assign commit = pend_valid && !fetch && !mcr_busy;

   ram_array #(
      .word_t (mem_pkg::data_word_t),
      .DEPTH  (mem_pkg::VRAM_WORDS)
   ) i_ram (
      .clk   (clk),
      .we    (commit),
      .waddr (pend_addr),
      .wdata (pend_data),
      .raddr (req.addr),
      .rdata (rsp.rdata)
   );

   always_ff @(posedge clk)
   begin
      if (reset)
         pend_valid <= 1'b0;
      else if (capture)
         pend_valid <= 1'b1;
      else if (commit)
         pend_valid <= 1'b0;
   end

   // address and data of the posted write
   always_ff @(posedge clk)
   begin
      if (capture)
      begin
         pend_addr <= req.addr;
         pend_data <= req.wdata;
      end
   end

   // ---------------------------------------------------------------------------
   // status flags
   // ---------------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ready_q <= 1'b0;
         done_q  <= 1'b0;
      end
      else
      begin
         // ready trails the read request by one cycle
         ready_q <= req.rd;
         // one cycle after the commit edge
         done_q  <= commit;
      end
   end

   assign rsp.ready = ready_q;
   assign rsp.done  = done_q;

endmodule

/* design/mem_subsystem.sv */
// memory subsystem top: microcode store, main memory and video memory ports

`timescale 1ns/1ps

module mem_subsystem (
   input  logic               clk,
   input  logic               reset,
   input  logic               prefetch,
   input  logic               fetch,

   // microcode store
   input  mem_pkg::mcr_req_t  mcr_req,
   output mem_pkg::mcr_word_t mcr_rdata,
   output logic               mcr_done,

   // main memory
   input  mem_pkg::dram_req_t dram_req,
   output mem_pkg::dram_rsp_t dram_rsp,

   // video memory
   input  mem_pkg::vram_req_t vram_req,
   output mem_pkg::vram_rsp_t vram_rsp
);

   // microcode write in progress, holds off video commits
   logic mcr_busy;

   // ---------------------------------------------------------------------------
   // microcode store
   // ---------------------------------------------------------------------------
   mcr_store i_mcr_store (
      .clk      (clk),
      .reset    (reset),
      .prefetch (prefetch),
      .req      (mcr_req),
      .rdata    (mcr_rdata),
      .done     (mcr_done),
      .busy     (mcr_busy)
   );

   // ---------------------------------------------------------------------------
   // main memory port
   // ---------------------------------------------------------------------------
   dram_port i_dram_port (
      .clk   (clk),
      .reset (reset),
      .req   (dram_req),
      .rsp   (dram_rsp)
   );

   // ---------------------------------------------------------------------------
   // video memory port
   // ---------------------------------------------------------------------------

   // fetch and the microcode write status decide when posted writes land
   vram_port i_vram_port (
      .clk      (clk),
      .reset    (reset),
      .fetch    (fetch),
      .mcr_busy (mcr_busy),
      .req      (vram_req),
      .rsp      (vram_rsp)
   );

endmodule

/* tb/tb_mem_subsystem.sv */
// directed testbench for the microcode, main and video memory ports of the memory subsystem

`timescale 1ns/1ps

module tb_mem_subsystem;

   localparam int ACK_TIMEOUT = 40;

   logic                clk;
   logic                reset;
   logic                prefetch;
   logic                fetch;
   mem_pkg::mcr_req_t   mcr_req;
   mem_pkg::mcr_word_t  mcr_rdata;
   logic                mcr_done;
   mem_pkg::dram_req_t  dram_req;
   mem_pkg::dram_rsp_t  dram_rsp;
   mem_pkg::vram_req_t  vram_req;
   mem_pkg::vram_rsp_t  vram_rsp;

   integer seed;
   int     test_errs;
   int     pass_cnt;
   int     fail_cnt;

   // reference memories where absent words read as zero
   mem_pkg::mcr_word_t  mcr_model [int];
   mem_pkg::data_word_t dram_model [int];
   mem_pkg::data_word_t vram_model [int];

   mem_subsystem i_dut (
      .clk       (clk),
      .reset     (reset),
      .prefetch  (prefetch),
      .fetch     (fetch),
      .mcr_req   (mcr_req),
      .mcr_rdata (mcr_rdata),
      .mcr_done  (mcr_done),
      .dram_req  (dram_req),
      .dram_rsp  (dram_rsp),
      .vram_req  (vram_req),
      .vram_rsp  (vram_rsp)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------
   function automatic logic [31:0] rand32();
      rand32 = $random(seed);
   endfunction

   function automatic logic [63:0] mcr_expect(input int a);
      if (mcr_model.exists(a))
         return 64'(mcr_model[a]);
      return 64'd0;
   endfunction

   // past the installed words everything reads as ones
   function automatic logic [63:0] dram_expect(input int a);
      if (a >= mem_pkg::DRAM_WORDS)
         return 64'(32'hffff_ffff);
      if (dram_model.exists(a))
         return 64'(dram_model[a]);
      return 64'd0;
   endfunction

   function automatic logic [63:0] vram_expect(input int a);
      if (vram_model.exists(a))
         return 64'(vram_model[a]);
      return 64'd0;
   endfunction

   task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] got);
      if (exp !== got)
      begin
         $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, got);
         test_errs++;
      end
   endtask

   task automatic end_test(input string name);
      if (test_errs == 0)
      begin
         pass_cnt++;
         $display("%s: ok", name);
      end
      else
      begin
         fail_cnt++;
         $display("%s: FAILED with %0d errors", name, test_errs);
      end
      test_errs = 0;
   endtask

   // counts falling edges until ready or done shows up
   task automatic wait_dram_ack(output int cycles);
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end
      while (!(dram_rsp.ready || dram_rsp.done) && cycles < ACK_TIMEOUT);
      if (!(dram_rsp.ready || dram_rsp.done))
      begin
         $display("timeout while waiting for the main memory acknowledge");
         test_errs++;
      end
   endtask

   // one request dropped right after it was accepted
   task automatic dram_access(input logic wr, input int a, input logic [31:0] d);
      int cycles;
      @(negedge clk);
      dram_req.addr  = 22'(a);
      dram_req.wdata = d;
      dram_req.rd    = !wr;
      dram_req.wr    = wr;
      if (wr && a < mem_pkg::DRAM_WORDS)
         dram_model[a] = d;
      @(negedge clk);
      dram_req.rd = 1'b0;
      dram_req.wr = 1'b0;
      wait_dram_ack(cycles);
      expect_eq("dram ack latency", 64'(mem_pkg::DRAM_LATENCY), 64'(cycles));
      expect_eq("dram_rsp.ready", 64'(!wr), 64'(dram_rsp.ready));
      expect_eq("dram_rsp.done", 64'(wr), 64'(dram_rsp.done));
      if (!wr)
         expect_eq("dram_rsp.rdata", dram_expect(a), 64'(dram_rsp.rdata));
      @(negedge clk);
      expect_eq("dram_rsp.ready", 64'd0, 64'(dram_rsp.ready));
      expect_eq("dram_rsp.done", 64'd0, 64'(dram_rsp.done));
   endtask

   task automatic prefetch_check(input int a);
      @(negedge clk);
      mcr_req.addr = 14'(a);
      prefetch     = 1'b1;
      @(negedge clk);
      prefetch = 1'b0;
      expect_eq("mcr_rdata", mcr_expect(a), 64'(mcr_rdata));
   endtask

   // ------------------------------------------------------------------------
   // tests
   // ------------------------------------------------------------------------
   task automatic reset_state();
      @(negedge clk);
      expect_eq("mcr_done", 64'd0, 64'(mcr_done));
      expect_eq("mcr_rdata", 64'd0, 64'(mcr_rdata));
      expect_eq("dram_rsp.ready", 64'd0, 64'(dram_rsp.ready));
      expect_eq("dram_rsp.done", 64'd0, 64'(dram_rsp.done));
      expect_eq("vram_rsp.ready", 64'd0, 64'(vram_rsp.ready));
      expect_eq("vram_rsp.done", 64'd0, 64'(vram_rsp.done));
      end_test("reset_state");
   endtask

   task automatic mcr_write_read();
      int          addrs [4];
      logic [63:0] w;
      for (int i = 0; i < 4; i++)
      begin
         addrs[i] = int'(rand32() % mem_pkg::MCR_WORDS);
         w        = {rand32(), rand32()};
         @(negedge clk);
         mcr_req.addr  = 14'(addrs[i]);
         mcr_req.wdata = w[48:0];
         mcr_req.we    = 1'b1;
         mcr_model[addrs[i]] = w[48:0];
         @(negedge clk);
         expect_eq("mcr_done", 64'd1, 64'(mcr_done));
         mcr_req.we = 1'b0;
         @(negedge clk);
         expect_eq("mcr_done", 64'd0, 64'(mcr_done));
      end
      for (int i = 0; i < 4; i++)
         prefetch_check(addrs[i]);
      end_test("mcr_write_read");
   endtask

   task automatic dram_read_write();
      int a [3];
      int far;
      for (int i = 0; i < 3; i++)
      begin
         a[i] = int'(rand32() % mem_pkg::DRAM_WORDS);
         dram_access(1'b1, a[i], rand32());
      end
      for (int i = 0; i < 3; i++)
         dram_access(1'b0, a[i], 32'd0);
      // aliases a[0] in the low bits and must not touch it
      far = mem_pkg::DRAM_WORDS + a[0];
      dram_access(1'b0, far, 32'd0);
      dram_access(1'b1, far, rand32());
      dram_access(1'b0, a[0], 32'd0);
      end_test("dram_read_write");
   endtask

   task automatic dram_back_pressure();
      int x;
      int y;
      int cycles;
      x = int'(rand32() % mem_pkg::DRAM_WORDS);
      y = (x + 1) % mem_pkg::DRAM_WORDS;
      dram_access(1'b1, x, rand32());
      dram_access(1'b1, y, rand32());
      @(negedge clk);
      dram_req.addr = 22'(x);
      dram_req.rd   = 1'b1;
      // second read held while the first is in flight
      @(negedge clk);
      dram_req.addr = 22'(y);
      wait_dram_ack(cycles);
      expect_eq("dram first ack latency", 64'(mem_pkg::DRAM_LATENCY), 64'(cycles));
      expect_eq("dram_rsp.ready", 64'd1, 64'(dram_rsp.ready));
      expect_eq("dram_rsp.rdata", dram_expect(x), 64'(dram_rsp.rdata));
      // one acknowledge cycle and then the full latency again
      wait_dram_ack(cycles);
      dram_req.rd = 1'b0;
      expect_eq("dram second ack latency", 64'(mem_pkg::DRAM_LATENCY + 1), 64'(cycles));
      expect_eq("dram_rsp.ready", 64'd1, 64'(dram_rsp.ready));
      expect_eq("dram_rsp.rdata", dram_expect(y), 64'(dram_rsp.rdata));
      for (int i = 0; i < mem_pkg::DRAM_LATENCY + 2; i++)
      begin
         @(negedge clk);
         expect_eq("dram_rsp.ready", 64'd0, 64'(dram_rsp.ready));
         expect_eq("dram_rsp.done", 64'd0, 64'(dram_rsp.done));
      end
      end_test("dram_back_pressure");
   endtask

   task automatic vram_posted_write();
      int          a;
      int          cycles;
      logic [31:0] d;
      a = int'(rand32() % mem_pkg::VRAM_WORDS);
      d = rand32();
      @(negedge clk);
      fetch          = 1'b1;
      vram_req.addr  = 15'(a);
      vram_req.wdata = d;
      vram_req.wr    = 1'b1;
      @(negedge clk);
      vram_req.wr = 1'b0;
      // fetch blocks the commit so old contents stay visible
      for (int i = 0; i < 6; i++)
      begin
         expect_eq("vram_rsp.done", 64'd0, 64'(vram_rsp.done));
         expect_eq("vram_rsp.rdata", vram_expect(a), 64'(vram_rsp.rdata));
         @(negedge clk);
      end
      fetch  = 1'b0;
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end
      while (!vram_rsp.done && cycles < ACK_TIMEOUT);
      if (!vram_rsp.done)
      begin
         $display("timeout while waiting for the video write to commit");
         test_errs++;
      end
      vram_model[a] = d;
      expect_eq("vram_rsp.rdata", vram_expect(a), 64'(vram_rsp.rdata));
      expect_eq("vram_rsp.ready", 64'd0, 64'(vram_rsp.ready));
      vram_req.rd = 1'b1;
      @(negedge clk);
      expect_eq("vram_rsp.done", 64'd0, 64'(vram_rsp.done));
      expect_eq("vram_rsp.ready", 64'd1, 64'(vram_rsp.ready));
      vram_req.rd = 1'b0;
      @(negedge clk);
      expect_eq("vram_rsp.ready", 64'd0, 64'(vram_rsp.ready));
      end_test("vram_posted_write");
   endtask

   task automatic vram_defer_on_mcr();
      int          va;
      int          ma;
      int          cycles;
      logic [31:0] d;
      logic [63:0] w;
      logic        busy_prev;
      logic        mcr_seen;
      va = int'(rand32() % mem_pkg::VRAM_WORDS);
      ma = int'(rand32() % mem_pkg::MCR_WORDS);
      d  = rand32();
      w  = {rand32(), rand32()};
      @(negedge clk);
      mcr_req.addr   = 14'(ma);
      mcr_req.wdata  = w[48:0];
      mcr_req.we     = 1'b1;
      vram_req.addr  = 15'(va);
      vram_req.wdata = d;
      vram_req.wr    = 1'b1;
      mcr_model[ma]  = w[48:0];
      busy_prev = 1'b0;
      mcr_seen  = 1'b0;
      cycles    = 0;
      do
      begin
         @(negedge clk);
         cycles++;
         mcr_req.we  = 1'b0;
         vram_req.wr = 1'b0;
         // done reflects the previous edge where busy was last sampled
         if (vram_rsp.done && (busy_prev || !mcr_seen))
         begin
            $display("video write committed while a microcode write was in progress");
            test_errs++;
         end
         mcr_seen  = mcr_seen | mcr_done;
         busy_prev = mcr_done;
      end
      while (!vram_rsp.done && cycles < ACK_TIMEOUT);
      if (!vram_rsp.done)
      begin
         $display("timeout while waiting for the deferred video write");
         test_errs++;
      end
      vram_model[va] = d;
      expect_eq("vram_rsp.rdata", vram_expect(va), 64'(vram_rsp.rdata));
      prefetch_check(ma);
      end_test("vram_defer_on_mcr");
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial
   begin
      seed      = 32'ha4a1;
      test_errs = 0;
      pass_cnt  = 0;
      fail_cnt  = 0;
      reset     = 1'b1;
      prefetch  = 1'b0;
      fetch     = 1'b0;
      mcr_req   = '0;
      dram_req  = '0;
      vram_req  = '0;
      repeat (5) @(negedge clk);
      reset = 1'b0;
      reset_state();
      mcr_write_read();
      dram_read_write();
      dram_back_pressure();
      vram_posted_write();
      vram_defer_on_mcr();
      $display("summary: %0d run, %0d ok, %0d with errors", pass_cnt + fail_cnt,
               pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

/* files.f */
common/mem_pkg.sv
design/ram_array.sv
mcr/mcr_store.sv
dram/dram_port.sv
vram/vram_port.sv
design/mem_subsystem.sv
tb/tb_mem_subsystem.sv

/* Makefile */
# Verilator build for the memory subsystem

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
RTL_TOP   ?= mem_subsystem
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
